//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - files:
      - logic/mem_pkg.sv
      - logic/byte_ram.sv
      - logic/mem_ctrl.sv
      - logic/apb_data_bridge.sv
      - logic/mem_subsystem.sv
  - target: test
    files:
      - verif/mem_subsystem_properties.sv
      - verif/tb_mem_subsystem.sv

//--- logic/apb_data_bridge.sv
`timescale 1ns/1ns

module apb_data_bridge (
    input logic clock,
    input logic reset,

    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [mem_pkg::paddr_width-1:0] paddr,
    input logic [mem_pkg::data_width-1:0] pwdata,
    input logic [mem_pkg::bytes_per_word-1:0] pstrb,
    output logic [mem_pkg::data_width-1:0] prdata,
    output logic pready,

    output logic load_req,
    output logic [mem_pkg::addr_width-1:0] load_addr,
    output logic [2:0] load_length,
    output logic load_signed,
    input logic load_ready,
    input mem_pkg::mem_word_u load_data,

    output logic store_req,
    output logic [mem_pkg::addr_width-1:0] store_addr,
    output logic [mem_pkg::byte_width-1:0] store_byte,
    input logic store_done
);

    logic [1:0] state;
    logic [mem_pkg::bytes_per_word-1:0] strobe_left;
    logic [mem_pkg::bytes_per_word-1:0] strobe_rest;
    logic [1:0] store_index;
    logic [mem_pkg::size_width-1:0] size_code;
    logic setup;
    mem_pkg::mem_word_u wdata_view;

    assign setup = psel && !penable && (state == mem_pkg::state_idle);
    assign size_code = paddr[mem_pkg::addr_width +: mem_pkg::size_width];

    always_comb begin
        case (size_code)
            mem_pkg::size_byte_u, mem_pkg::size_byte_s: load_length = 3'd1;
            mem_pkg::size_half_u, mem_pkg::size_half_s: load_length = 3'd2;
            default: load_length = 3'd4;                // size_word and unused codes
        endcase
    end

    assign load_signed = (size_code == mem_pkg::size_byte_s) || (size_code == mem_pkg::size_half_s);
    assign load_addr = paddr[mem_pkg::addr_width-1:0];
    assign load_req = (setup && !pwrite) || (state == mem_pkg::state_load_wait);  // From setup on

    // Lowest strobe still pending is written first
    always_comb begin
        store_index = 2'd0;
        for (int i = mem_pkg::bytes_per_word - 1; i >= 0; i--) begin
            if (strobe_left[i]) begin
                store_index = 2'(i);
            end
        end
    end

    assign strobe_rest = strobe_left & (strobe_left - 1'b1);
    assign wdata_view = pwdata;
    assign store_req = (state == mem_pkg::state_store_walk);
    assign store_addr = load_addr + mem_pkg::addr_width'(store_index);
    assign store_byte = wdata_view.bytes[store_index];

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= mem_pkg::state_idle;
            strobe_left <= '0;
            pready <= 1'b0;
        end else begin
            pready <= 1'b0;
            case (state)
                mem_pkg::state_idle: begin
                    if (setup && !pwrite) begin
                        state <= mem_pkg::state_load_wait;
                    end else if (setup && |pstrb) begin
                        state <= mem_pkg::state_store_walk;
                        strobe_left <= pstrb;
                    end else if (setup) begin
                        pready <= 1'b1;                 // Nothing to write
                    end
                end
                mem_pkg::state_load_wait: begin
                    if (load_ready) begin
                        state <= mem_pkg::state_idle;
                        pready <= 1'b1;
                    end
                end
                mem_pkg::state_store_walk: begin
                    if (store_done) begin
                        strobe_left <= strobe_rest;
                        if (strobe_rest == '0) begin
                            state <= mem_pkg::state_idle;
                            pready <= 1'b1;
                        end
                    end
                end
                default: state <= mem_pkg::state_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (load_ready) begin
            prdata <= load_data.word;
        end
    end

endmodule

//--- logic/byte_ram.sv
`timescale 1ns/1ns

module byte_ram (
    input logic clock,
    input logic write,
    input logic [mem_pkg::addr_width-1:0] addr,
    input logic [mem_pkg::byte_width-1:0] wdata,
    output logic [mem_pkg::byte_width-1:0] rdata
);

    logic [mem_pkg::byte_width-1:0] mem [mem_pkg::ram_depth];

    always_ff @(posedge clock) begin
        if (write) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];                             // Old byte comes back on a write cycle
    end

endmodule

//--- logic/mem_ctrl.sv
`timescale 1ns/1ns

module mem_ctrl (
    input logic clock,
    input logic reset,

    input logic fetch_read,
    input logic [mem_pkg::addr_width-1:0] fetch_addr,
    input logic fetch_discard,
    output logic fetch_busy,
    output logic fetch_ready,
    output mem_pkg::mem_word_u fetch_data,

    input logic load_req,
    input logic [mem_pkg::addr_width-1:0] load_addr,
    input logic [2:0] load_length,
    input logic load_signed,
    output logic load_ready,
    output mem_pkg::mem_word_u load_data,

    input logic store_req,
    input logic [mem_pkg::addr_width-1:0] store_addr,
    input logic [mem_pkg::byte_width-1:0] store_byte,
    output logic store_done,

    output logic ram_write,
    output logic [mem_pkg::addr_width-1:0] ram_addr,
    output logic [mem_pkg::byte_width-1:0] ram_wdata,
    input logic [mem_pkg::byte_width-1:0] ram_rdata
);

    logic [2:0] ld_issue;                               // Load bytes already addressed
    logic load_wait;
    logic load_active;
    logic load_done;
    logic grant_load;
    logic ext_bit;
    mem_pkg::mem_word_u ld_buf;
    mem_pkg::mem_word_u ld_next;
    mem_pkg::mem_word_u ld_ext;

    // The prefetch engine also serves fetch misses by retargeting itself
    logic pf_valid;
    logic [mem_pkg::addr_width-1:0] pf_addr;
    logic [mem_pkg::addr_width-1:0] pf_base;
    logic [2:0] pf_issue;
    logic [2:0] pf_idx;
    logic [2:0] pf_recv;
    logic [2:0] pf_recv_next;
    logic pf_miss;
    logic pf_active;
    logic pf_arrive;
    logic grant_pf;
    mem_pkg::mem_word_u pf_buf;
    mem_pkg::mem_word_u pf_next;
    logic fetch_wait;
    logic fetch_hit_done;

    logic rd_load;                                      // Byte on ram_rdata belongs to the load
    logic rd_pf;
    logic [1:0] rd_index;

    assign load_wait = load_req && !load_ready;
    assign load_active = load_wait && (ld_issue < load_length);
    assign load_done = rd_load && (rd_index == 2'(load_length - 3'd1));

    always_comb begin
        ld_next = ld_buf;
        if (rd_load) begin
            ld_next.bytes[rd_index] = ram_rdata;
        end
    end

    always_comb begin
        ld_ext = ld_next;
        ext_bit = 1'b0;
        case (load_length)
            3'd1: begin
                ext_bit = load_signed && ld_next.bytes[0][mem_pkg::byte_width-1];
                ld_ext.bytes[3:1] = {3{{mem_pkg::byte_width{ext_bit}}}};
            end
            3'd2: begin
                ext_bit = load_signed && ld_next.bytes[1][mem_pkg::byte_width-1];
                ld_ext.bytes[3:2] = {2{{mem_pkg::byte_width{ext_bit}}}};
            end
            default: begin
            end
        endcase
    end

    assign fetch_wait = fetch_read && !fetch_ready && !fetch_discard;
    assign pf_miss = fetch_wait && !(pf_valid && pf_addr == fetch_addr);
    assign pf_base = pf_miss ? fetch_addr : pf_addr;
    assign pf_idx = pf_miss ? 3'd0 : pf_issue;
    assign pf_active = !fetch_discard && (pf_miss || (pf_valid && !pf_issue[2]));
    assign pf_arrive = rd_pf && pf_valid && !pf_miss && !fetch_discard;  // Stale bytes dropped
    assign pf_recv_next = pf_recv + 3'(pf_arrive);
    assign fetch_hit_done = fetch_wait && !pf_miss && pf_recv_next[2];

    always_comb begin
        pf_next = pf_buf;
        if (pf_arrive) begin
            pf_next.bytes[rd_index] = ram_rdata;
        end
    end

    // Fixed priority: data load, then fetch or prefetch, then store
    always_comb begin
        grant_load = 1'b0;
        grant_pf = 1'b0;
        store_done = 1'b0;
        ram_addr = load_addr + mem_pkg::addr_width'(ld_issue);
        if (load_active) begin
            grant_load = 1'b1;
        end else if (pf_active) begin
            grant_pf = 1'b1;
            ram_addr = pf_base + mem_pkg::addr_width'(pf_idx);
        end else if (store_req) begin
            store_done = 1'b1;
            ram_addr = store_addr;
        end
    end

    assign ram_write = store_done;
    assign ram_wdata = store_byte;

    always_ff @(posedge clock) begin
        if (reset) begin
            ld_issue <= '0;
            load_ready <= 1'b0;
            fetch_ready <= 1'b0;
            fetch_busy <= 1'b0;
            pf_valid <= 1'b0;
            pf_issue <= '0;
            pf_recv <= '0;
            rd_load <= 1'b0;
            rd_pf <= 1'b0;
        end else begin
            load_ready <= load_done;
            fetch_ready <= fetch_hit_done;
            fetch_busy <= fetch_wait && load_active && !fetch_hit_done;  // Held off by a load
            rd_load <= grant_load;
            rd_pf <= grant_pf;
            if (load_done) begin
                ld_issue <= '0;
            end else if (grant_load) begin
                ld_issue <= ld_issue + 3'd1;
            end
            if (fetch_discard || store_done) begin
                pf_valid <= 1'b0;                       // A store may overwrite buffered bytes
            end else if (pf_miss) begin
                pf_valid <= 1'b1;
                pf_issue <= 3'(grant_pf);
                pf_recv <= '0;
            end else if (fetch_hit_done) begin
                pf_issue <= '0;                         // Start on the next sequential word
                pf_recv <= '0;
            end else begin
                pf_issue <= pf_issue + 3'(grant_pf);
                pf_recv <= pf_recv_next;
            end
        end
    end

    always_ff @(posedge clock) begin
        rd_index <= grant_load ? ld_issue[1:0] : pf_idx[1:0];
        ld_buf <= ld_next;
        pf_buf <= pf_next;
        if (pf_miss) begin
            pf_addr <= fetch_addr;
        end else if (fetch_hit_done) begin
            pf_addr <= pf_addr + mem_pkg::addr_width'(mem_pkg::bytes_per_word);
        end
        if (load_done) begin
            load_data <= ld_ext;
        end
        if (fetch_hit_done) begin
            fetch_data <= pf_next;
        end
    end

endmodule

//--- logic/mem_pkg.sv
package mem_pkg;

    localparam int addr_width = 12;                     // 4 KiB of byte storage
    localparam int data_width = 32;
    localparam int byte_width = 8;
    localparam int paddr_width = 16;
    localparam int ram_depth = 1 << addr_width;
    localparam int bytes_per_word = data_width / byte_width;

    // Size code sits in paddr just above the byte address
    localparam int size_width = 3;
    localparam logic [size_width-1:0] size_byte_u = 3'd0;
    localparam logic [size_width-1:0] size_half_u = 3'd1;
    localparam logic [size_width-1:0] size_word = 3'd2;
    localparam logic [size_width-1:0] size_byte_s = 3'd4;
    localparam logic [size_width-1:0] size_half_s = 3'd5;

    localparam logic [1:0] state_idle = 2'd0;
    localparam logic [1:0] state_load_wait = 2'd1;
    localparam logic [1:0] state_store_walk = 2'd2;

    // Byte 0 is the least significant byte of the word
    typedef union packed {
        logic [data_width-1:0] word;
        logic [bytes_per_word-1:0][byte_width-1:0] bytes;
    } mem_word_u;

endpackage

//--- logic/mem_subsystem.sv
`timescale 1ns/1ns

module mem_subsystem (
    input logic clock,
    input logic reset,

    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [mem_pkg::paddr_width-1:0] paddr,
    input logic [mem_pkg::data_width-1:0] pwdata,
    input logic [mem_pkg::bytes_per_word-1:0] pstrb,
    output logic [mem_pkg::data_width-1:0] prdata,
    output logic pready,

    input logic fetch_read,
    input logic [mem_pkg::addr_width-1:0] fetch_addr,
    input logic fetch_discard,
    output logic fetch_busy,
    output logic fetch_ready,
    output logic [mem_pkg::data_width-1:0] fetch_data
);

    logic load_req;
    logic [mem_pkg::addr_width-1:0] load_addr;
    logic [2:0] load_length;
    logic load_signed;
    logic load_ready;
    mem_pkg::mem_word_u load_data;
    logic store_req;
    logic [mem_pkg::addr_width-1:0] store_addr;
    logic [mem_pkg::byte_width-1:0] store_byte;
    logic store_done;
    logic ram_write;
    logic [mem_pkg::addr_width-1:0] ram_addr;
    logic [mem_pkg::byte_width-1:0] ram_wdata;
    logic [mem_pkg::byte_width-1:0] ram_rdata;

    apb_data_bridge apb_data_bridge_inst (
        .clock(clock),
        .reset(reset),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .pstrb(pstrb),
        .prdata(prdata),
        .pready(pready),
        .load_req(load_req),
        .load_addr(load_addr),
        .load_length(load_length),
        .load_signed(load_signed),
        .load_ready(load_ready),
        .load_data(load_data),
        .store_req(store_req),
        .store_addr(store_addr),
        .store_byte(store_byte),
        .store_done(store_done)
    );

    mem_ctrl mem_ctrl_inst (
        .clock(clock),
        .reset(reset),
        .fetch_read(fetch_read),
        .fetch_addr(fetch_addr),
        .fetch_discard(fetch_discard),
        .fetch_busy(fetch_busy),
        .fetch_ready(fetch_ready),
        .fetch_data(fetch_data),
        .load_req(load_req),
        .load_addr(load_addr),
        .load_length(load_length),
        .load_signed(load_signed),
        .load_ready(load_ready),
        .load_data(load_data),
        .store_req(store_req),
        .store_addr(store_addr),
        .store_byte(store_byte),
        .store_done(store_done),
        .ram_write(ram_write),
        .ram_addr(ram_addr),
        .ram_wdata(ram_wdata),
        .ram_rdata(ram_rdata)
    );

    byte_ram byte_ram_inst (
        .clock(clock),
        .write(ram_write),
        .addr(ram_addr),
        .wdata(ram_wdata),
        .rdata(ram_rdata)
    );

endmodule

//--- tb.f
logic/mem_pkg.sv
logic/byte_ram.sv
logic/mem_ctrl.sv
logic/apb_data_bridge.sv
logic/mem_subsystem.sv
verif/mem_subsystem_properties.sv
verif/tb_mem_subsystem.sv

//--- verif/mem_subsystem_properties.sv
`timescale 1ns/1ns

module mem_subsystem_properties (
    input logic clock,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [mem_pkg::paddr_width-1:0] paddr,
    input logic [mem_pkg::data_width-1:0] pwdata,
    input logic [mem_pkg::bytes_per_word-1:0] pstrb,
    input logic pready,
    input logic fetch_read,
    input logic [mem_pkg::addr_width-1:0] fetch_addr,
    input logic fetch_discard,
    input logic fetch_busy,
    input logic fetch_ready
);

    int failures = 0;

    reset_clears_outputs: assert property (
        @(posedge clock) reset |=> !pready && !fetch_ready && !fetch_busy
    ) else begin
        failures++;
        $error("pready, fetch_ready or fetch_busy high after reset");
    end

    pready_pulse: assert property (@(posedge clock) disable iff (reset) pready |=> !pready)
    else begin
        failures++;
        $error("pready held high for more than one cycle");
    end

    fetch_ready_pulse: assert property (
        @(posedge clock) disable iff (reset) fetch_ready |=> !fetch_ready
    ) else begin
        failures++;
        $error("fetch_ready held high for more than one cycle");
    end

    pready_in_access: assert property (
        @(posedge clock) disable iff (reset) pready |-> psel && penable
    ) else begin
        failures++;
        $error("pready outside an APB access phase");
    end

    // From setup until pready the request is frozen
    apb_held_stable: assert property (
        @(posedge clock) disable iff (reset) psel && !pready |=> psel && penable
            && $stable(pwrite) && $stable(paddr) && $stable(pwdata) && $stable(pstrb)
    ) else begin
        failures++;
        $error("APB request changed before pready");
    end

    fetch_held_stable: assert property (
        @(posedge clock) disable iff (reset) fetch_read && !fetch_ready && !fetch_discard
            |=> fetch_discard || fetch_ready || (fetch_read && $stable(fetch_addr))
    ) else begin
        failures++;
        $error("Fetch request dropped or changed before fetch_ready");
    end

endmodule

bind mem_subsystem mem_subsystem_properties mem_subsystem_properties_inst (
    .clock(clock),
    .reset(reset),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .pstrb(pstrb),
    .pready(pready),
    .fetch_read(fetch_read),
    .fetch_addr(fetch_addr),
    .fetch_discard(fetch_discard),
    .fetch_busy(fetch_busy),
    .fetch_ready(fetch_ready)
);

//--- verif/tb_mem_subsystem.sv
`timescale 1ns/1ns

module tb_mem_subsystem;

    localparam int word_tests = 16;
    localparam int sub_tests = 24;
    localparam int mixed_tests = 30;
    localparam int apb_total = 2 * word_tests + sub_tests + 1 + mixed_tests;
    localparam int fetch_total = 8 + mixed_tests;
    // A 4-byte write squeezed between prefetches takes about 30 cycles
    localparam int cycle_limit = 2 * (apb_total * 30 + fetch_total * 12);
    localparam logic [mem_pkg::size_width-1:0] read_sizes [5] = '{mem_pkg::size_byte_u,
        mem_pkg::size_half_u, mem_pkg::size_byte_s, mem_pkg::size_half_s, mem_pkg::size_word};

    logic clock;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [mem_pkg::paddr_width-1:0] paddr;
    logic [mem_pkg::data_width-1:0] pwdata;
    logic [mem_pkg::bytes_per_word-1:0] pstrb;
    logic [mem_pkg::data_width-1:0] prdata;
    logic pready;
    logic fetch_read;
    logic [mem_pkg::addr_width-1:0] fetch_addr;
    logic fetch_discard;
    logic fetch_busy;
    logic fetch_ready;
    logic [mem_pkg::data_width-1:0] fetch_data;

    logic [mem_pkg::byte_width-1:0] shadow [mem_pkg::ram_depth];
    logic fetch_outstanding = 1'b0;                     // A fetch is waiting for its answer
    int error_count = 0;
    int cycle_count = 0;

    mem_subsystem mem_subsystem_inst (.*);

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    no_stray_fetch: assert property (
        @(posedge clock) disable iff (reset) fetch_ready |-> fetch_outstanding
    ) else begin
        error_count++;
        $display("fetch_ready arrived with no fetch outstanding in cycle %0d", cycle_count);
    end

    // Little-endian assembly from the shadow bytes, then sign or zero extension
    function automatic logic [mem_pkg::data_width-1:0] expected_load(
        input logic [mem_pkg::addr_width-1:0] addr,
        input logic [mem_pkg::size_width-1:0] size
    );
        mem_pkg::mem_word_u value;
        int length;
        logic sign;
        value.word = '0;
        case (size)
            mem_pkg::size_word: length = 4;
            mem_pkg::size_half_u, mem_pkg::size_half_s: length = 2;
            default: length = 1;
        endcase
        for (int i = 0; i < length; i++) begin
            value.bytes[i] = shadow[addr + mem_pkg::addr_width'(i)];
        end
        sign = value.bytes[length-1][mem_pkg::byte_width-1];
        if (sign && (size == mem_pkg::size_byte_s || size == mem_pkg::size_half_s)) begin
            for (int i = length; i < mem_pkg::bytes_per_word; i++) begin
                value.bytes[i] = '1;
            end
        end
        return value.word;
    endfunction

    task automatic apb_access(
        input logic write,
        input logic [mem_pkg::size_width-1:0] size,
        input logic [mem_pkg::addr_width-1:0] addr,
        input logic [mem_pkg::data_width-1:0] data,
        input logic [mem_pkg::bytes_per_word-1:0] strobe
    );
        mem_pkg::mem_word_u wdata_view;
        logic [mem_pkg::data_width-1:0] expect_data;
        expect_data = expected_load(addr, size);
        wdata_view.word = data;
        @(posedge clock);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= write;
        paddr <= {1'b0, size, addr};
        pwdata <= data;
        pstrb <= strobe;
        @(posedge clock);
        penable <= 1'b1;
        @(posedge clock);
        while (!pready) begin
            @(posedge clock);
        end
        psel <= 1'b0;
        penable <= 1'b0;
        if (write) begin
            for (int i = 0; i < mem_pkg::bytes_per_word; i++) begin
                if (strobe[i]) begin
                    shadow[addr + mem_pkg::addr_width'(i)] = wdata_view.bytes[i];
                end
            end
        end else begin
            assert (prdata == expect_data) else begin
                error_count++;
                $display("** Error: prdata at paddr %h expected %h got %h", paddr, expect_data,
                    prdata);
            end
        end
    endtask

    task automatic fetch_word(input logic [mem_pkg::addr_width-1:0] addr);
        logic [mem_pkg::data_width-1:0] expect_data;
        expect_data = expected_load(addr, mem_pkg::size_word);
        @(posedge clock);
        fetch_read <= 1'b1;
        fetch_addr <= addr;
        fetch_outstanding <= 1'b1;
        @(posedge clock);
        while (!fetch_ready) begin
            @(posedge clock);
        end
        fetch_read <= 1'b0;
        fetch_outstanding <= 1'b0;
        assert (fetch_data == expect_data) else begin
            error_count++;
            $display("** Error: fetch_data at %h expected %h got %h", addr, expect_data, fetch_data);
        end
    endtask

    // Cancels a miss in the cycle its last byte comes back
    task automatic discard_fetch(input logic [mem_pkg::addr_width-1:0] addr);
        @(posedge clock);
        fetch_read <= 1'b1;
        fetch_addr <= addr;
        fetch_outstanding <= 1'b1;
        repeat (4) @(posedge clock);
        fetch_discard <= 1'b1;
        fetch_outstanding <= 1'b0;
        @(posedge clock);
        fetch_read <= 1'b0;
        fetch_discard <= 1'b0;
        repeat (8) @(posedge clock);
    endtask

    task automatic report_and_finish(input logic timed_out);
        int protocol_failures;
        protocol_failures = mem_subsystem_inst.mem_subsystem_properties_inst.failures;
        $display("Errors: %0d data, %0d protocol, %0d timeout", error_count, protocol_failures,
            timed_out);
        if (timed_out || error_count + protocol_failures != 0) begin
            $display("Result: FAILED");
        end else begin
            $display("Result: PASSED");
        end
        $finish;
    endtask

    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with a transfer still unanswered", cycle_limit);
        report_and_finish(1'b1);
    end

    initial begin
        logic [mem_pkg::addr_width-1:0] addr_list [word_tests];
        logic [mem_pkg::addr_width-1:0] base;
        logic [mem_pkg::addr_width-1:0] fetch_pc;
        void'($urandom(32'h80d7));
        for (int i = 0; i < mem_pkg::ram_depth; i++) begin
            shadow[i] = 8'(i * 37) ^ 8'(i >> 7);
            mem_subsystem_inst.byte_ram_inst.mem[i] = shadow[i];
        end
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        pstrb = '0;
        fetch_read = 1'b0;
        fetch_addr = '0;
        fetch_discard = 1'b0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;

        for (int i = 0; i < word_tests; i++) begin
            addr_list[i] = 12'(($urandom % 512) * 4);
            apb_access(1'b1, mem_pkg::size_word, addr_list[i], $urandom, 4'($urandom));
        end
        for (int i = 0; i < word_tests; i++) begin
            apb_access(1'b0, mem_pkg::size_word, addr_list[i], '0, '0);
        end
        for (int i = 0; i < sub_tests; i++) begin
            apb_access(1'b0, read_sizes[i % 4], 12'($urandom), '0, '0);
        end

        base = 12'(($urandom % 256) * 4);
        fetch_word(base);
        fetch_word(base + 12'd4);
        fetch_word(base + 12'd8);
        fetch_word(base);                               // Leaves base+4 in the prefetch buffer
        apb_access(1'b1, mem_pkg::size_word, base + 12'd4, $urandom, 4'hf);
        fetch_word(base + 12'd4);
        discard_fetch(base + 12'h100);
        fetch_word(base + 12'h204);

        // Fetches stay below 0x400 and APB traffic above 0x800
        fetch_pc = base;
        fork
            begin
                for (int i = 0; i < mixed_tests; i++) begin
                    apb_access(1'($urandom), read_sizes[$urandom % 5],
                        12'h800 + 12'($urandom % 2032), $urandom, 4'($urandom));
                end
            end
            begin
                for (int i = 0; i < mixed_tests; i++) begin
                    if ($urandom % 4 == 0) begin
                        fetch_pc = 12'(($urandom % 256) * 4);
                    end else begin
                        fetch_pc = (fetch_pc + 12'd4) & 12'h3fc;
                    end
                    fetch_word(fetch_pc);
                end
            end
        join
        repeat (4) @(posedge clock);
        report_and_finish(1'b0);
    end

endmodule
